// ==== Makefile ====
# Verilator build and run for the pre-charge modulation sequencer

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_modulation
RTL_TOP    ?= modulation_top
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_modulation.sv ====
// directed testbench for the pre-charge modulation sequencer
// drives config words and the comparator, follows the phase outputs at
// the pins and checks every result record against counts taken here
// inputs change 2 time units after the rising edge, outputs are read
// on the falling edge

`default_nettype none

module tb_modulation;

  localparam int CFG_DEPTH  = 2;
  localparam int RES_DEPTH  = 4;
  localparam int WAIT_LIMIT = 2000;
  localparam logic [31:0] LFSR_SEED = 32'h418028f0;

  logic                    clk;
  logic                    reset;
  logic                    cfg_valid;
  logic                    cfg_ready;
  modulation_pkg::cfg_t    cfg_data;
  logic                    res_valid;
  logic                    res_ready;
  modulation_pkg::result_t res_data;
  logic                    comp;
  logic                    sw_pc_ctl;
  logic [3:0]              azmux;
  logic                    led0;
  logic [7:0]              monitor;

  // comparator mode 0 holds it low, 1 high and 2 takes lfsr bits
  int          comp_mode;
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  logic [15:0] exp_seq;
  // tallies of the cycle being watched
  int          hi_tally;
  int          lo_tally;
  int          hi_cycles;
  int          lo_cycles;

  modulation_top #(
    .CFG_DEPTH (CFG_DEPTH),
    .RES_DEPTH (RES_DEPTH)
  ) UUT (
    .clk       (clk),
    .reset     (reset),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .cfg_data  (cfg_data),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .comp      (comp),
    .sw_pc_ctl (sw_pc_ctl),
    .azmux     (azmux),
    .led0      (led0),
    .monitor   (monitor)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // 32-bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per comparator bit
  always @(posedge clk)
  begin
    #2;
    case (comp_mode)
      0: comp = 1'b0;
      1: comp = 1'b1;
      default:
      begin
        lfsr = lfsr_step(lfsr);
        comp = lfsr[0];
      end
    endcase
  end

  function automatic modulation_pkg::cfg_t make_cfg(input logic [23:0] pc,
                                                    input logic [31:0] smp,
                                                    input logic [3:0]  lo,
                                                    input logic        run);
    modulation_pkg::cfg_t c;
    c.precharge_len = pc;
    c.sample_len    = smp;
    c.azmux_lo      = lo;
    c.run           = run;
    return c;
  endfunction

  task automatic set_comp(input int mode);
    @(negedge clk);
    comp_mode = mode;
  endtask

  //////////////////////////////
  // checks and reporting
  //////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    checks++;
    assert (got == exp)
    else
    begin
      errors++;
      $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("ERROR t=%0t %s", $time, what);
    end
  endtask

  // ends the run when a wait runs out
  task automatic abort_run(input string what);
    errors++;
    $display("ERROR t=%0t timed out waiting for %s", $time, what);
    $display("summary: %0d checks, %0d errors", checks, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  //////////////////////////////
  // stream tasks
  //////////////////////////////

  task automatic send_cfg(input modulation_pkg::cfg_t c);
    int n;
    n = 0;
    @(posedge clk);
    #2;
    cfg_valid = 1'b1;
    cfg_data  = c;
    @(negedge clk);
    while (!cfg_ready)
    begin
      if (n == WAIT_LIMIT)
        abort_run("cfg_ready");
      n++;
      @(negedge clk);
    end
    // taken on the next edge
    @(posedge clk);
    #2;
    cfg_valid = 1'b0;
  endtask

  // waits for one record, watching the pins every cycle until it shows
  // expects res_ready high
  task automatic get_record(input modulation_pkg::cfg_t c,
                            output modulation_pkg::result_t r);
    int         n;
    logic [2:0] code;
    logic       hi_smp;
    logic       hi_win;
    n         = 0;
    hi_tally  = 0;
    lo_tally  = 0;
    hi_cycles = 0;
    lo_cycles = 0;
    @(negedge clk);
    while (!res_valid)
    begin
      code = monitor[7:5];
      if (code == modulation_pkg::BOOT)
      begin
        hi_tally  = 0;
        lo_tally  = 0;
        hi_cycles = 0;
        lo_cycles = 0;
      end
      // switch on means the hi sample
      if (sw_pc_ctl)
      begin
        hi_cycles++;
        hi_tally += comp;
      end
      if (code == modulation_pkg::SAMPLE_LO)
      begin
        lo_cycles++;
        lo_tally += comp;
      end
      // pins expected for the phase code on the monitor
      hi_smp = (code == modulation_pkg::SAMPLE_HI);
      hi_win = (code == modulation_pkg::SETTLE) || hi_smp;
      check_eq("monitor[4:0]", monitor[4:0], {3'b000, hi_smp, hi_win});
      check_eq("sw_pc_ctl", sw_pc_ctl, hi_smp);
      check_eq("azmux", azmux, hi_win ? modulation_pkg::AZMUX_HI : c.azmux_lo);
      check_eq("led0", led0, sw_pc_ctl);
      if (n == WAIT_LIMIT)
        abort_run("res_valid");
      n++;
      @(negedge clk);
    end
    r = res_data;
    check_eq("res_data.seq_num", r.seq_num, exp_seq);
    exp_seq = exp_seq + 16'd1;
    @(posedge clk);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (monitor != 8'd0 || res_valid)
    begin
      if (n == WAIT_LIMIT)
        abort_run("idle phase");
      n++;
      @(negedge clk);
    end
  endtask

  // a run word followed by a stop word gives exactly one cycle
  task automatic run_one_cycle(input modulation_pkg::cfg_t c,
                               output modulation_pkg::result_t r);
    modulation_pkg::cfg_t stop;
    stop     = c;
    stop.run = 1'b0;
    send_cfg(c);
    send_cfg(stop);
    get_record(c, r);
    wait_idle();
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    check_eq("sw_pc_ctl", sw_pc_ctl, 1'b0);
    check_eq("azmux", azmux, 4'd0);
    check_eq("led0", led0, 1'b0);
    check_eq("monitor", monitor, 8'd0);
    check_eq("res_valid", res_valid, 1'b0);
    check_eq("cfg_ready", cfg_ready, 1'b1);
  endtask

  task automatic test_fixed_levels();
    modulation_pkg::cfg_t    c;
    modulation_pkg::result_t r;
    c = make_cfg(24'd3, 32'd10, 4'd5, 1'b1);
    set_comp(1);
    run_one_cycle(c, r);
    check_eq("res_data.hi_count", r.hi_count, 32'd10);
    check_eq("res_data.lo_count", r.lo_count, 32'd10);
    set_comp(0);
    run_one_cycle(c, r);
    check_eq("res_data.hi_count", r.hi_count, 32'd0);
    check_eq("res_data.lo_count", r.lo_count, 32'd0);
  endtask

  // azmux, led0 and the monitor flags are checked cycle by cycle inside get_record
  task automatic test_phase_outputs();
    modulation_pkg::cfg_t    c;
    modulation_pkg::result_t r;
    c = make_cfg(24'd4, 32'd7, 4'd3, 1'b1);
    set_comp(2);
    run_one_cycle(c, r);
    check_eq("sw_pc_ctl high cycles", hi_cycles, 32'd7);
    check_eq("sample lo cycles", lo_cycles, 32'd7);
  endtask

  task automatic test_random_comp();
    modulation_pkg::cfg_t    c;
    modulation_pkg::result_t r;
    c = make_cfg(24'd2, 32'd40, 4'd6, 1'b1);
    set_comp(2);
    run_one_cycle(c, r);
    check_eq("res_data.hi_count", r.hi_count, hi_tally);
    check_eq("res_data.lo_count", r.lo_count, lo_tally);
  endtask

  task automatic test_back_pressure();
    modulation_pkg::cfg_t    c;
    modulation_pkg::result_t r;
    int                      n;
    int                      done_run;
    int                      k;
    c = make_cfg(24'd3, 32'd3, 4'd2, 1'b1);
    set_comp(1);
    @(posedge clk);
    #2;
    res_ready = 1'b0;
    send_cfg(c);
    // a done longer than one cycle means the stall reached the sequencer
    n        = 0;
    done_run = 0;
    while (done_run < 8)
    begin
      @(negedge clk);
      if (monitor[7:5] == modulation_pkg::DONE)
        done_run++;
      else
        done_run = 0;
      if (n == WAIT_LIMIT)
        abort_run("sequencer stall in done");
      n++;
    end
    repeat (6)
    begin
      @(negedge clk);
      check_true("res_valid dropped during stall", res_valid);
      check_eq("monitor phase", monitor[7:5], modulation_pkg::DONE);
    end
    @(posedge clk);
    #2;
    res_ready = 1'b1;
    // the full fifo drains first in seq_num order
    for (k = 0; k < RES_DEPTH; k++)
    begin
      get_record(c, r);
      check_eq("res_data.hi_count", r.hi_count, 32'd3);
      check_eq("res_data.lo_count", r.lo_count, 32'd3);
    end
    // then the record held in the accumulator
    get_record(c, r);
    check_eq("res_data.hi_count", r.hi_count, 32'd3);
    check_eq("res_data.lo_count", r.lo_count, 32'd3);
    // a fresh record shows that cycling went on
    get_record(c, r);
    check_eq("res_data.hi_count", r.hi_count, 32'd3);
    check_eq("res_data.lo_count", r.lo_count, 32'd3);
  endtask

  task automatic test_stop_reconfig();
    modulation_pkg::cfg_t    c;
    modulation_pkg::result_t r;
    int                      n;
    int                      quiet;
    int                      seen;
    c = make_cfg(24'd3, 32'd3, 4'd2, 1'b0);
    send_cfg(c);
    // the running cycle repeats every 16 clocks
    // 20 clocks without a record after it mean cycling has stopped
    n     = 0;
    quiet = 0;
    seen  = 0;
    while (seen == 0 || quiet < 20)
    begin
      @(negedge clk);
      if (res_valid)
      begin
        r = res_data;
        check_eq("res_data.seq_num", r.seq_num, exp_seq);
        check_eq("res_data.hi_count", r.hi_count, 32'd3);
        check_eq("res_data.lo_count", r.lo_count, 32'd3);
        exp_seq = exp_seq + 16'd1;
        seen++;
        quiet = 0;
      end
      else
        quiet++;
      if (n == WAIT_LIMIT)
        abort_run("end of cycling");
      n++;
    end
    check_eq("records after the stop word", seen, 32'd1);
    check_eq("monitor", monitor, 8'd0);
    // new lengths
    c = make_cfg(24'd5, 32'd13, 4'd9, 1'b1);
    set_comp(1);
    run_one_cycle(c, r);
    check_eq("res_data.hi_count", r.hi_count, 32'd13);
    check_eq("res_data.lo_count", r.lo_count, 32'd13);
    check_eq("sw_pc_ctl high cycles", hi_cycles, 32'd13);
    check_eq("sample lo cycles", lo_cycles, 32'd13);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    clk       = 1'b0;
    reset     = 1'b1;
    cfg_valid = 1'b0;
    cfg_data  = '0;
    res_ready = 1'b1;
    comp      = 1'b0;
    comp_mode = 0;
    lfsr      = LFSR_SEED;
    errors    = 0;
    checks    = 0;
    exp_seq   = 16'd0;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    test_reset_state();
    test_fixed_levels();
    test_phase_outputs();
    test_random_comp();
    test_back_pressure();
    test_stop_reconfig();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/meas_accumulator.sv ====
// comparator counter for the two sample phases
// counts clock cycles with comp high during sample hi and sample lo,
// then offers the counts as one result record while the sequencer
// sits in done, and keeps busy high until the result fifo takes it

`default_nettype none

module meas_accumulator (
  input  wire                      clk,
  input  wire                      reset,
  input  modulation_pkg::phase_t   phase,
  // comparator, already synchronous to clk
  input  wire                      comp,
  // result stream to the output fifo
  output logic                     res_valid,
  input  wire                      res_ready,
  output modulation_pkg::result_t  res_data,
  // back-pressure to the sequencer
  output logic                     busy
);

  logic [31:0] hi_count;
  logic [31:0] lo_count;
  logic [15:0] seq_num;
  // a lo sample has run and its record is not yet taken
  logic        pending;
  logic        accept;

  //////////////////////////////
  // counters
  //////////////////////////////

  // cleared on every boot, frozen outside the sample phases
  // so they hold the record through done
  always_ff @(posedge clk)
  begin
    case (phase)
      modulation_pkg::BOOT:
      begin
        hi_count <= 32'd0;
        lo_count <= 32'd0;
      end
      modulation_pkg::SAMPLE_HI:
        hi_count <= hi_count + {31'd0, comp};
      modulation_pkg::SAMPLE_LO:
        lo_count <= lo_count + {31'd0, comp};
      default:
      begin
        hi_count <= hi_count;
        lo_count <= lo_count;
      end
    endcase
  end

  //////////////////////////////
  // record handoff
  //////////////////////////////

  // the last lo cycle lands in lo_count on the edge into done,
  // so the record is complete on the first done cycle
  assign res_valid = pending && (phase == modulation_pkg::DONE);
  assign accept    = res_valid && res_ready;

  // busy only while the record waits, the accepting cycle releases done
  assign busy = res_valid && !res_ready;

  always_comb
  begin
    res_data.seq_num  = seq_num;
    res_data.hi_count = hi_count;
    res_data.lo_count = lo_count;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pending <= 1'b0;
      seq_num <= 16'd0;
    end
    else
    begin
      if (phase == modulation_pkg::SAMPLE_LO)
        pending <= 1'b1;
      else if (accept)
        pending <= 1'b0;
      // numbering wraps at 16 bits
      if (accept)
        seq_num <= seq_num + 16'd1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/modulation_pkg.sv ====
// shared definitions for the pre-charge modulation sequencer
// holds the config word, the phase encoding, the result record and
// the monitor bus layout, along with the switch and mux constants
// every rtl file refers to these by scoped name

`default_nettype none

package modulation_pkg;

  //////////////////////////////
  // switch and mux constants
  //////////////////////////////

  // pre-charge switch levels
  localparam logic SW_PC_BOOT   = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

  // pc-out sits on S1 of the upper mux bank
  localparam logic [3:0] S1_INDEX = 4'd0;
  localparam logic [3:0] AZMUX_HI = 4'd8 + S1_INDEX;

  //////////////////////////////
  // config, phase, result
  //////////////////////////////

  // one configuration word, 61 bits
  typedef struct packed {
    logic [23:0] precharge_len;  // cycles per boot, settle or protect phase
    logic [31:0] sample_len;     // cycles per sample phase
    logic [3:0]  azmux_lo;       // mux code outside the hi phases
    logic        run;            // keep cycling after the current cycle
  } cfg_t;

  // sequencer phase, also shown on monitor bits 7..5
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    BOOT      = 3'd1,
    SETTLE    = 3'd2,
    SAMPLE_HI = 3'd3,
    PROTECT   = 3'd4,
    SAMPLE_LO = 3'd5,
    DONE      = 3'd6
  } phase_t;

  // one measurement record, 80 bits
  typedef struct packed {
    logic [15:0] seq_num;   // wraps
    logic [31:0] hi_count;  // comparator high cycles in sample hi
    logic [31:0] lo_count;  // comparator high cycles in sample lo
  } result_t;

  // monitor bus layout, msb first
  typedef struct packed {
    phase_t     code;       // bits 7..5
    logic [2:0] spare;      // bits 4..2, held low
    logic       hi_sample;  // bit 1, sample hi only
    logic       hi_window;  // bit 0, settle through sample hi
  } monitor_t;

endpackage

`default_nettype wire

// ==== rtl/modulation_seq.sv ====
// phase sequencer for the pre-charge modulation cycle
// steps boot, settle, sample hi, protect and sample lo from one config
// word, then waits in done until the accumulator has handed off its record
// switch, mux, led and monitor are registered and change on phase entry

`default_nettype none

module modulation_seq (
  input  wire                   clk,
  input  wire                   reset,
  // config stream from the input fifo
  input  wire                   cfg_valid,
  output logic                  cfg_ready,
  input  modulation_pkg::cfg_t  cfg_data,
  // accumulator handshake
  input  wire                   acc_busy,
  output modulation_pkg::phase_t phase,
  // front end pins
  output logic                  sw_pc_ctl,
  output logic [3:0]            azmux,
  output logic                  led0,
  output logic [7:0]            monitor
);

  // active config and phase down-counter
  modulation_pkg::cfg_t     cfg_act;
  modulation_pkg::cfg_t     cfg_nxt;
  modulation_pkg::phase_t   phase_nxt;
  logic [31:0]              cnt;
  logic [31:0]              cnt_nxt;
  modulation_pkg::monitor_t mon_q;
  modulation_pkg::monitor_t mon_nxt;

  // a zero length still gives one cycle
  function automatic logic [31:0] pc_len(input modulation_pkg::cfg_t c);
    logic [31:0] len;
    len = {8'd0, c.precharge_len};
    return (len == 32'd0) ? 32'd1 : len;
  endfunction

  function automatic logic [31:0] smp_len(input modulation_pkg::cfg_t c);
    return (c.sample_len == 32'd0) ? 32'd1 : c.sample_len;
  endfunction

  //////////////////////////////
  // next phase
  //////////////////////////////

  always_comb
  begin
    phase_nxt = phase;
    cfg_nxt   = cfg_act;
    cnt_nxt   = cnt;
    cfg_ready = 1'b0;
    case (phase)
      modulation_pkg::IDLE:
      begin
        // always ready, a config without run just updates the active word
        cfg_ready = 1'b1;
        if (cfg_valid)
        begin
          cfg_nxt = cfg_data;
          if (cfg_data.run)
          begin
            phase_nxt = modulation_pkg::BOOT;
            cnt_nxt   = pc_len(cfg_data);
          end
        end
      end
      // pc to boot, protect the signal before the mux moves
      modulation_pkg::BOOT:
        if (cnt == 32'd1)
        begin
          phase_nxt = modulation_pkg::SETTLE;
          cnt_nxt   = pc_len(cfg_act);
        end
        else
          cnt_nxt = cnt - 32'd1;
      // mux onto pc-out while the switch still protects
      modulation_pkg::SETTLE:
        if (cnt == 32'd1)
        begin
          phase_nxt = modulation_pkg::SAMPLE_HI;
          cnt_nxt   = smp_len(cfg_act);
        end
        else
          cnt_nxt = cnt - 32'd1;
      // pc to signal, hi measurement
      modulation_pkg::SAMPLE_HI:
        if (cnt == 32'd1)
        begin
          phase_nxt = modulation_pkg::PROTECT;
          cnt_nxt   = pc_len(cfg_act);
        end
        else
          cnt_nxt = cnt - 32'd1;
      // back to boot before the mux drops to lo
      modulation_pkg::PROTECT:
        if (cnt == 32'd1)
        begin
          phase_nxt = modulation_pkg::SAMPLE_LO;
          cnt_nxt   = smp_len(cfg_act);
        end
        else
          cnt_nxt = cnt - 32'd1;
      modulation_pkg::SAMPLE_LO:
        if (cnt == 32'd1)
          phase_nxt = modulation_pkg::DONE;
        else
          cnt_nxt = cnt - 32'd1;
      modulation_pkg::DONE:
        // held here while the record cannot be handed off
        if (!acc_busy)
        begin
          cfg_ready = 1'b1;
          if (cfg_valid)
            cfg_nxt = cfg_data;
          if (cfg_nxt.run)
          begin
            phase_nxt = modulation_pkg::BOOT;
            cnt_nxt   = pc_len(cfg_nxt);
          end
          else
            phase_nxt = modulation_pkg::IDLE;
        end
      default:
        phase_nxt = modulation_pkg::IDLE;
    endcase
  end

  // monitor view of the coming phase
  always_comb
  begin
    mon_nxt.code      = phase_nxt;
    mon_nxt.spare     = 3'b000;
    mon_nxt.hi_sample = (phase_nxt == modulation_pkg::SAMPLE_HI);
    mon_nxt.hi_window = (phase_nxt == modulation_pkg::SETTLE) ||
                        (phase_nxt == modulation_pkg::SAMPLE_HI);
  end

  //////////////////////////////
  // state and pin registers
  //////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase     <= modulation_pkg::IDLE;
      cfg_act   <= '0;
      cnt       <= 32'd0;
      sw_pc_ctl <= modulation_pkg::SW_PC_BOOT;
      azmux     <= 4'd0;
      led0      <= 1'b0;
      mon_q     <= '0;
    end
    else
    begin
      phase   <= phase_nxt;
      cfg_act <= cfg_nxt;
      cnt     <= cnt_nxt;
      mon_q   <= mon_nxt;
      // signal goes through only in sample hi
      sw_pc_ctl <= (phase_nxt == modulation_pkg::SAMPLE_HI) ?
                   modulation_pkg::SW_PC_SIGNAL : modulation_pkg::SW_PC_BOOT;
      led0      <= (phase_nxt == modulation_pkg::SAMPLE_HI);
      // pc-out selected for the hi window, lo input everywhere else
      azmux     <= mon_nxt.hi_window ? modulation_pkg::AZMUX_HI : cfg_nxt.azmux_lo;
    end
  end

  assign monitor = mon_q;

endmodule

`default_nettype wire

// ==== rtl/modulation_top.sv ====
// top level of the pre-charge modulation sequencer
// config words enter through a small fifo, the sequencer drives the
// pre-charge switch and the az mux, the accumulator counts the comparator
// and its records leave through a second fifo
// fifo depths are set here and passed down

`default_nettype none

module modulation_top #(
  parameter int CFG_DEPTH = 2,
  parameter int RES_DEPTH = 4
) (
  input  wire                      clk,
  input  wire                      reset,
  // config stream in
  input  wire                      cfg_valid,
  output logic                     cfg_ready,
  input  modulation_pkg::cfg_t     cfg_data,
  // result stream out
  output logic                     res_valid,
  input  wire                      res_ready,
  output modulation_pkg::result_t  res_data,
  // comparator and front end pins
  input  wire                      comp,
  output logic                     sw_pc_ctl,
  output logic [3:0]               azmux,
  output logic                     led0,
  output logic [7:0]               monitor
);

  // config fifo to sequencer
  logic                     cfg_q_valid;
  logic                     cfg_q_ready;
  modulation_pkg::cfg_t     cfg_q_data;

  // sequencer to accumulator
  modulation_pkg::phase_t   phase;
  logic                     acc_busy;

  // accumulator to result fifo
  logic                     res_in_valid;
  logic                     res_in_ready;
  modulation_pkg::result_t  res_in_data;

  //////////////////////////////
  // input side
  //////////////////////////////

  stream_fifo #(
    .payload_t (modulation_pkg::cfg_t),
    .DEPTH     (CFG_DEPTH)
  ) u_cfg_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (cfg_valid),
    .in_ready  (cfg_ready),
    .in_data   (cfg_data),
    .out_valid (cfg_q_valid),
    .out_ready (cfg_q_ready),
    .out_data  (cfg_q_data)
  );

  modulation_seq u_seq (
    .clk       (clk),
    .reset     (reset),
    .cfg_valid (cfg_q_valid),
    .cfg_ready (cfg_q_ready),
    .cfg_data  (cfg_q_data),
    .acc_busy  (acc_busy),
    .phase     (phase),
    .sw_pc_ctl (sw_pc_ctl),
    .azmux     (azmux),
    .led0      (led0),
    .monitor   (monitor)
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  meas_accumulator u_acc (
    .clk       (clk),
    .reset     (reset),
    .phase     (phase),
    .comp      (comp),
    .res_valid (res_in_valid),
    .res_ready (res_in_ready),
    .res_data  (res_in_data),
    .busy      (acc_busy)
  );

  // a full result fifo holds the accumulator busy, which stalls done
  stream_fifo #(
    .payload_t (modulation_pkg::result_t),
    .DEPTH     (RES_DEPTH)
  ) u_res_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (res_in_valid),
    .in_ready  (res_in_ready),
    .in_data   (res_in_data),
    .out_valid (res_valid),
    .out_ready (res_ready),
    .out_data  (res_data)
  );

endmodule

`default_nettype wire

// ==== rtl/stream_fifo.sv ====
// small valid/ready fifo used on both stream ends of the sequencer
// the payload type is a parameter so one block carries both the
// config words and the result records
// a push and a pop may share a cycle, also when the buffer is full

`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 2
) (
  input  wire      clk,
  input  wire      reset,
  // write side
  input  wire      in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // read side
  output logic     out_valid,
  input  wire      out_ready,
  output payload_t out_data
);

  // pointer and occupancy widths
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            full;
  logic            push;
  logic            pop;

  assign full      = (count == CW'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  // full only blocks the writer if nothing leaves this cycle
  assign in_ready  = !full || out_ready;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // storage array
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  // pointers and occupancy
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // count moves only when exactly one side fires
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/modulation_pkg.sv
rtl/stream_fifo.sv
rtl/modulation_seq.sv
rtl/meas_accumulator.sv
rtl/modulation_top.sv
bench/tb_modulation.sv
